/* sim/pwm_timer_tests.txt */
# name op sawtooth start end threshold presc mode ticks exp_count exp_pwm exp_ends
# op 0 stop/update/start, 1 update while running, 2 reset then start, 3 stop only
saw_basic    0 1   0   9   5 0 0  7   7 0 0
saw_wrap     0 1   3   7   7 0 0 13   6 1 2
saw_presc    0 1  10  20  12 2 0 14  14 0 0
tri_basic    0 0   2   5   4 0 0  8   4 0 1
tri_presc    0 0   0   3   2 1 0 15   1 1 1
toggle_saw   0 1   0   4   2 0 1 12   2 0 2
toggle_tri   0 0   1   4   3 0 1  9   4 1 1
live_setup   0 1   0   5   3 0 0  3   3 0 0
live_update  1 1  10  12  11 0 0  6  10 1 2
reset_start  2 1  10  12  11 0 0  1  11 0 0
stop_freeze  3 1  10  12  11 0 0  5  11 0 0
tri_slow     0 0 100 103 102 3 0 20 101 1 0
tri_short    0 0   5   6   6 0 0  5   6 0 2

/* filelist.f */
+incdir+src
src/pwm_timer_pkg.sv
src/timer_ctrl.sv
src/event_prescaler.sv
src/up_down_counter.sv
src/pwm_compare.sv
src/pwm_timer.sv
sim/pwm_timer_checker.sv
sim/pwm_timer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the PWM timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timescale 1ns/1ps -f filelist.f \
	--top-module pwm_timer_tb -Mdir "$build_dir" -o pwm_timer_tb
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

"./$build_dir/pwm_timer_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$log_file"; then
	exit 0
fi
echo "Pass message not found in $log_file"
exit 1

/* sim/pwm_timer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwm_timer_settings.svh"

module pwm_timer_tb import pwm_timer_pkg::*; ();
	localparam int ACK_TIMEOUT = 20;

	logic                     clk_i;
	logic                     rstn_i;
	logic                     cmd_req_i;
	timer_cmd_e               cmd_i;
	timer_cfg_t               cfg_i;
	logic                     tick_i;
	logic                     cmd_ack_o;
	logic                     pwm_o;
	logic [`PWM_CNT_BITS-1:0] count_o;
	logic                     period_end_o;

	logic [31:0] rng = 32'h22371711;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          end_total = 0;
	int          prev_count = 0;
	bit          hung = 1'b0;
	string       cur_name = "after_reset";

	pwm_timer uut (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.cmd_req_i    (cmd_req_i),
		.cmd_i        (cmd_i),
		.cfg_i        (cfg_i),
		.tick_i       (tick_i),
		.cmd_ack_o    (cmd_ack_o),
		.pwm_o        (pwm_o),
		.count_o      (count_o),
		.period_end_o (period_end_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Period end pulses seen since reset
	always @(negedge clk_i) begin
		if (period_end_o)
			end_total <= end_total + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("MISMATCH %s %s expected %0d actual %0d", cur_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s ok", cur_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_name, errors - errors_before);
		end
	endtask

	// Four-phase handshake, each phase has its own timeout
	task automatic issue_cmd(input timer_cmd_e cmd, input timer_cfg_t cfg);
		int waited;
		if (hung)
			return;
		cmd_i     = cmd;
		cfg_i     = cfg;
		cmd_req_i = 1'b1;
		waited    = 0;
		while (!cmd_ack_o && waited < ACK_TIMEOUT) begin
			@(negedge clk_i);
			waited++;
		end
		if (!cmd_ack_o) begin
			$display("ERROR %s: command %s was never acknowledged", cur_name, cmd.name());
			errors++;
			hung = 1'b1;
		end
		cmd_req_i = 1'b0;
		waited    = 0;
		while (cmd_ack_o && waited < ACK_TIMEOUT) begin
			@(negedge clk_i);
			waited++;
		end
		if (cmd_ack_o) begin
			$display("ERROR %s: acknowledge of %s stayed high", cur_name, cmd.name());
			errors++;
			hung = 1'b1;
		end
	endtask

	task automatic send_ticks(input int count);
		for (int i = 0; i < count; i++) begin
			rng    = lcg_next(rng);
			tick_i = 1'b1;
			@(negedge clk_i);
			tick_i = 1'b0;
			// One or two idle cycles
			repeat (1 + rng[16]) @(negedge clk_i);
		end
	endtask

	task automatic run_test(input int op, input timer_cfg_t cfg, input int ticks,
			input int exp_count, input int exp_pwm, input int exp_ends);
		int errors_before;
		int ends_before;
		errors_before = errors;
		case (op)
			0: begin
				issue_cmd(CMD_STOP, cfg);
				issue_cmd(CMD_UPDATE, cfg);
				check_value("count_o after load", int'(cfg.start), int'(count_o));
				issue_cmd(CMD_START, cfg);
			end
			1: begin
				issue_cmd(CMD_UPDATE, cfg);
				// Running, so the old count stays until the period ends
				check_value("count_o after update", prev_count, int'(count_o));
			end
			2: begin
				// Step away from the start value so the reload shows
				issue_cmd(CMD_START, cfg);
				send_ticks(1);
				issue_cmd(CMD_RESET, cfg);
				check_value("count_o after reset", int'(cfg.start), int'(count_o));
				issue_cmd(CMD_START, cfg);
			end
			default: issue_cmd(CMD_STOP, cfg);
		endcase
		ends_before = end_total;
		if (!hung) begin
			send_ticks(ticks);
			repeat (4) @(negedge clk_i);
			check_value("count_o", exp_count, int'(count_o));
			check_value("pwm_o", exp_pwm, int'(pwm_o));
			check_value("period ends", exp_ends, end_total - ends_before);
		end
		prev_count = exp_count;
		report_test(errors_before);
	endtask

	initial begin : main
		int         fd;
		string      line;
		string      name;
		int         op, saw, start, stop_val, thr, presc, mode;
		int         ticks, exp_count, exp_pwm, exp_ends;
		timer_cfg_t cfg;
		rstn_i    = 1'b0;
		cmd_req_i = 1'b0;
		cmd_i     = CMD_STOP;
		cfg_i     = '0;
		tick_i    = 1'b0;
		repeat (2) @(negedge clk_i);
		rstn_i = 1'b1;
		@(negedge clk_i);
		check_value("count_o", 0, int'(count_o));
		check_value("pwm_o", 0, int'(pwm_o));
		check_value("period_end_o", 0, int'(period_end_o));
		check_value("cmd_ack_o", 0, int'(cmd_ack_o));
		report_test(0);
		fd = $fopen("sim/pwm_timer_tests.txt", "r");
		if (fd == 0) begin
			$display("ERROR could not open sim/pwm_timer_tests.txt");
			errors++;
		end else begin
			while (!hung && $fgets(line, fd) != 0) begin
				// Comment and blank lines do not hold twelve columns
				if ($sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", name, op, saw,
						start, stop_val, thr, presc, mode, ticks, exp_count, exp_pwm,
						exp_ends) == 12) begin
					cfg.sawtooth  = saw[0];
					cfg.start     = start[`PWM_CNT_BITS-1:0];
					cfg.stop_val  = stop_val[`PWM_CNT_BITS-1:0];
					cfg.threshold = thr[`PWM_CNT_BITS-1:0];
					cfg.presc     = presc[`PWM_PRESC_BITS-1:0];
					cfg.mode      = out_mode_e'(mode[0]);
					cur_name      = name;
					run_test(op, cfg, ticks, exp_count, exp_pwm, exp_ends);
				end
			end
			$fclose(fd);
		end
		if (tests_run < 2) begin
			$display("ERROR no tests were read from the tests file");
			errors++;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/pwm_timer_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwm_timer_settings.svh"

module pwm_timer_checker import pwm_timer_pkg::*; (
	input wire logic                     clk_i,
	input wire logic                     rstn_i,
	input wire logic                     req_i,
	input wire logic                     ack_i,
	input wire cnt_status_t              status_i,
	input wire logic [`PWM_CNT_BITS-1:0] lo_i,
	input wire logic [`PWM_CNT_BITS-1:0] hi_i
);
	// Ack rises only for a request held through the execute cycle
	ack_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
		$rose(ack_i) |-> $past(req_i))
		else $error("acknowledge rose without a request");

	ack_fall: assert property (@(posedge clk_i) disable iff (!rstn_i)
		$fell(ack_i) |-> !$past(req_i))
		else $error("acknowledge dropped while the request was still high");

	req_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
		$rose(req_i) |-> !ack_i)
		else $error("new request raised before the acknowledge went low");

	// Every period closes back on the start value
	end_at_start: assert property (@(posedge clk_i) disable iff (!rstn_i)
		status_i.period_end |-> (status_i.value == lo_i))
		else $error("period end flagged away from the start value");

	// Only meaningful for a well-formed range
	in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(lo_i <= hi_i) |-> (status_i.value >= lo_i && status_i.value <= hi_i))
		else $error("counter value left the loaded range");

endmodule

bind pwm_timer pwm_timer_checker u_checker (
	.clk_i    (clk_i),
	.rstn_i   (rstn_i),
	.req_i    (cmd_req_i),
	.ack_i    (cmd_ack_o),
	.status_i (status),
	.lo_i     (u_counter.r_start),
	.hi_i     (u_counter.r_end)
);

`default_nettype wire

/* src/pwm_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwm_timer_settings.svh"

module pwm_timer import pwm_timer_pkg::*; (
	input  wire logic                  clk_i,
	input  wire logic                  rstn_i,
	input  wire logic                  cmd_req_i,
	input  wire timer_cmd_e            cmd_i,
	input  wire timer_cfg_t            cfg_i,
	input  wire logic                  tick_i,
	output logic                       cmd_ack_o,
	output logic                       pwm_o,
	output logic [`PWM_CNT_BITS-1:0]   count_o,
	output logic                       period_end_o
);
	logic        active;
	logic        upd;
	logic        rst_cnt;
	logic        cnt_evt;
	timer_cfg_t  cfg_held;
	cnt_status_t status;

	timer_ctrl u_ctrl (
		.clk_i     (clk_i),
		.rstn_i    (rstn_i),
		.cmd_req_i (cmd_req_i),
		.cmd_i     (cmd_i),
		.cfg_i     (cfg_i),
		.cmd_ack_o (cmd_ack_o),
		.active_o  (active),
		.upd_o     (upd),
		.rst_cnt_o (rst_cnt),
		.cfg_o     (cfg_held)
	);

	event_prescaler u_presc (
		.clk_i    (clk_i),
		.rstn_i   (rstn_i),
		.active_i (active),
		.tick_i   (tick_i),
		.presc_i  (cfg_held.presc),
		.evt_o    (cnt_evt)
	);

	up_down_counter u_counter (
		.clk_i           (clk_i),
		.rstn_i          (rstn_i),
		.cfg_i           (cfg_held),
		.ctrl_update_i   (upd),
		.ctrl_rst_i      (rst_cnt),
		.ctrl_active_i   (active),
		.counter_event_i (cnt_evt),
		.status_o        (status)
	);

	pwm_compare u_compare (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.status_i    (status),
		.threshold_i (cfg_held.threshold),
		.mode_i      (cfg_held.mode),
		.pwm_o       (pwm_o)
	);

	assign count_o      = status.value;
	assign period_end_o = status.period_end;

endmodule

`default_nettype wire

/* src/pwm_compare.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwm_timer_settings.svh"

module pwm_compare import pwm_timer_pkg::*; (
	input  wire logic                     clk_i,
	input  wire logic                     rstn_i,
	input  wire cnt_status_t              status_i,
	input  wire logic [`PWM_CNT_BITS-1:0] threshold_i,
	input  wire out_mode_e                mode_i,
	output logic                          pwm_o
);
	logic s_below;
	logic s_hit;

	assign s_below = (status_i.value < threshold_i);

	// Only a freshly applied count may toggle
	assign s_hit = status_i.evt && (status_i.value == threshold_i);

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_pwm
		if (!rstn_i) begin
			pwm_o <= 1'b0;
		end else begin
			case (mode_i)
				OUT_LEVEL: pwm_o <= s_below;
				OUT_TOGGLE: begin
					if (s_hit)
						pwm_o <= !pwm_o;
				end
				default: pwm_o <= s_below;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/up_down_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwm_timer_settings.svh"

module up_down_counter import pwm_timer_pkg::*; (
	input  wire logic       clk_i,
	input  wire logic       rstn_i,
	input  wire timer_cfg_t cfg_i,
	input  wire logic       ctrl_update_i,
	input  wire logic       ctrl_rst_i,
	input  wire logic       ctrl_active_i,
	input  wire logic       counter_event_i,
	output cnt_status_t     status_o
);
	logic [`PWM_CNT_BITS-1:0] r_value;
	logic [`PWM_CNT_BITS-1:0] r_start;
	logic [`PWM_CNT_BITS-1:0] r_end;
	logic                     r_direction;  // set while counting down
	logic                     r_sawtooth;
	logic                     r_pending;
	logic                     r_evt;
	logic                     r_period_end;

	logic [`PWM_CNT_BITS-1:0] s_value;
	logic [`PWM_CNT_BITS-1:0] s_dec;
	logic                     s_direction;
	logic                     s_wrap;
	logic                     s_step;
	logic                     s_load;

	assign s_step = counter_event_i & ctrl_active_i;
	assign s_dec  = r_value - 1'b1;

	// Next count for one applied event
	always_comb begin : proc_next
		s_value     = r_value + 1'b1;
		s_direction = r_direction;
		s_wrap      = 1'b0;
		if (r_sawtooth) begin
			if (r_value == r_end) begin
				s_value = r_start;
				s_wrap  = 1'b1;
			end
		end else if (r_start == r_end) begin
			// Degenerate triangle stays put
			s_value = r_start;
			s_wrap  = 1'b1;
		end else if (r_direction || (r_value == r_end)) begin
			s_value     = s_dec;
			s_direction = (s_dec != r_start);
			s_wrap      = (s_dec == r_start);
		end
	end

	// Reload at once when stopped, else on the event closing the period
	assign s_load = ctrl_rst_i
		|| (ctrl_update_i && !ctrl_active_i)
		|| (s_step && s_wrap && (r_pending || ctrl_update_i));

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_regs
		if (!rstn_i) begin
			r_value      <= '0;
			r_start      <= '0;
			r_end        <= '0;
			r_direction  <= 1'b0;
			r_sawtooth   <= 1'b1;
			r_pending    <= 1'b0;
			r_evt        <= 1'b0;
			r_period_end <= 1'b0;
		end else begin
			r_pending    <= (r_pending || ctrl_update_i) && !s_load;
			r_evt        <= s_step;
			r_period_end <= s_step && s_wrap;
			if (s_load) begin
				r_value     <= cfg_i.start;
				r_start     <= cfg_i.start;
				r_end       <= cfg_i.stop_val;
				r_sawtooth  <= cfg_i.sawtooth;
				r_direction <= 1'b0;
			end else if (s_step) begin
				r_value     <= s_value;
				r_direction <= s_direction;
			end
		end
	end

	assign status_o = '{value: r_value, evt: r_evt, period_end: r_period_end};

endmodule

`default_nettype wire

/* src/event_prescaler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwm_timer_settings.svh"

module event_prescaler (
	input  wire logic                       clk_i,
	input  wire logic                       rstn_i,
	input  wire logic                       active_i,
	input  wire logic                       tick_i,
	input  wire logic [`PWM_PRESC_BITS-1:0] presc_i,
	output logic                            evt_o
);
	// Ticks still needed before the next event
	logic [`PWM_PRESC_BITS-1:0] r_remain;

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_presc
		if (!rstn_i) begin
			r_remain <= '0;
			evt_o    <= 1'b0;
		end else begin
			evt_o <= 1'b0;
			if (!active_i) begin
				r_remain <= presc_i;
			end else if (tick_i) begin
				if (r_remain == '0) begin
					r_remain <= presc_i;
					evt_o    <= 1'b1;
				end else begin
					r_remain <= r_remain - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/timer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwm_timer_settings.svh"

module timer_ctrl import pwm_timer_pkg::*; (
	input  wire logic       clk_i,
	input  wire logic       rstn_i,
	input  wire logic       cmd_req_i,
	input  wire timer_cmd_e cmd_i,
	input  wire timer_cfg_t cfg_i,
	output logic            cmd_ack_o,
	output logic            active_o,
	output logic            upd_o,
	output logic            rst_cnt_o,
	output timer_cfg_t      cfg_o
);
	ctrl_state_e r_state;

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_fsm
		if (!rstn_i) begin
			r_state   <= ST_IDLE;
			cmd_ack_o <= 1'b0;
			active_o  <= 1'b0;
			upd_o     <= 1'b0;
			rst_cnt_o <= 1'b0;
			cfg_o     <= '0;
		end else begin
			// Pulses last a single cycle
			upd_o     <= 1'b0;
			rst_cnt_o <= 1'b0;
			case (r_state)
				ST_IDLE: begin
					if (cmd_req_i)
						r_state <= ST_EXEC;
				end
				ST_EXEC: begin
					case (cmd_i)
						CMD_START: active_o <= 1'b1;
						CMD_STOP:  active_o <= 1'b0;
						CMD_UPDATE: begin
							upd_o <= 1'b1;
							cfg_o <= cfg_i;
						end
						CMD_RESET: begin
							active_o  <= 1'b0;
							rst_cnt_o <= 1'b1;
						end
						default: active_o <= active_o;
					endcase
					cmd_ack_o <= 1'b1;
					r_state   <= ST_ACK;
				end
				ST_ACK: begin
					// Hold ack until the requester lets go
					if (!cmd_req_i) begin
						cmd_ack_o <= 1'b0;
						r_state   <= ST_IDLE;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/pwm_timer_pkg.sv */
`default_nettype none

`include "pwm_timer_settings.svh"

package pwm_timer_pkg;

	typedef enum logic [1:0] {
		CMD_START  = 2'd0,
		CMD_STOP   = 2'd1,
		CMD_UPDATE = 2'd2,
		CMD_RESET  = 2'd3
	} timer_cmd_e;

	typedef enum logic {
		OUT_LEVEL  = 1'b0,
		OUT_TOGGLE = 1'b1
	} out_mode_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_EXEC = 2'd1,
		ST_ACK  = 2'd2
	} ctrl_state_e;

	typedef struct packed {
		logic                       sawtooth;
		logic [`PWM_CNT_BITS-1:0]   start;
		logic [`PWM_CNT_BITS-1:0]   stop_val;
		logic [`PWM_CNT_BITS-1:0]   threshold;
		logic [`PWM_PRESC_BITS-1:0] presc;
		out_mode_e                  mode;
	} timer_cfg_t;

	// Value is the count after the last applied event
	typedef struct packed {
		logic [`PWM_CNT_BITS-1:0] value;
		logic                     evt;
		logic                     period_end;
	} cnt_status_t;

endpackage

`default_nettype wire

/* src/pwm_timer_settings.svh */
`ifndef PWM_TIMER_SETTINGS_SVH
`define PWM_TIMER_SETTINGS_SVH

// Counter, start, end and threshold width
`define PWM_CNT_BITS 16

// Prescaler ratio width, divides by ratio + 1
`define PWM_PRESC_BITS 8

`endif
